/* include/dmem_settings.svh */
`ifndef DMEM_SETTINGS_SVH
`define DMEM_SETTINGS_SVH

////////////////////////////////////////////////////////////////////////////
// data memory geometry
////////////////////////////////////////////////////////////////////////////

`define DMEM_NUM_BANKS 4 // identical ram banks behind the decoder.
`define DMEM_BANK_WORDS 256 // 32-bit words in each bank.

// word index inside one bank.
`define DMEM_IDX_BITS ($clog2(`DMEM_BANK_WORDS))

// bank number, taken from the word address just above the index.
`define DMEM_SEL_BITS ($clog2(`DMEM_NUM_BANKS))

// word address bits that fall inside the mapped region (4 KB).
`define DMEM_MAP_BITS (`DMEM_IDX_BITS + `DMEM_SEL_BITS)

`endif

/* logic/dmem_pkg.sv */
`default_nettype none

`include "dmem_settings.svh"

package dmem_pkg;

	////////////////////////////////////////////////////////////////////////////
	// plain vectors
	////////////////////////////////////////////////////////////////////////////

	typedef logic [31:0] word_t;
	typedef logic [29:0] bus_addr_t; // word address, byte offset dropped.
	typedef logic [3:0] reg_sel_t;
	typedef logic [1:0] acc_width_t;
	typedef logic [3:0] byte_en_t;
	typedef logic [`DMEM_IDX_BITS-1:0] bank_idx_t;
	typedef logic [`DMEM_SEL_BITS-1:0] bank_sel_t;

	// access widths, 2 and 3 both mean a full word.
	localparam acc_width_t ACC_BYTE = 2'd0;
	localparam acc_width_t ACC_HALF = 2'd1;

	////////////////////////////////////////////////////////////////////////////
	// bus structs
	////////////////////////////////////////////////////////////////////////////

	typedef struct packed {
		bus_addr_t addr;
		byte_en_t byte_en;
		logic wr_en;
		word_t wr_data; // already steered into its lanes.
	} bus_req_t;

	typedef struct packed {
		logic strobe; // one cycle per access.
		logic wr_en;
		bank_idx_t idx;
		byte_en_t byte_en;
		word_t wr_data;
	} bank_req_t;

	typedef struct packed {
		logic ack;
		word_t data;
	} bank_resp_t;

	typedef enum logic {
		DEC_IDLE,
		DEC_WAIT
	} dec_state_t;

endpackage

`default_nettype wire

/* logic/mem_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_stage (
	input logic clk,
	input logic rst,
	input logic load,
	input logic store,
	input dmem_pkg::word_t addr,
	input dmem_pkg::word_t mdr,
	input logic mem_wr_en,
	input dmem_pkg::acc_width_t width,
	input dmem_pkg::word_t wr_val,
	input logic update_rd,
	input dmem_pkg::reg_sel_t rd_sel,
	input logic dbg_en,
	input logic dbg_access,
	input logic dbg_wr_en,
	input dmem_pkg::word_t dbg_addr,
	input dmem_pkg::acc_width_t dbg_width,
	input dmem_pkg::word_t dbg_wr_val,
	input logic d_ack,
	input logic d_error,
	input dmem_pkg::word_t d_data,
	output dmem_pkg::word_t reg_wr_val,
	output logic update_rd_out,
	output dmem_pkg::reg_sel_t rd_sel_out,
	output logic complete,
	output logic data_abort,
	output logic busy,
	output dmem_pkg::word_t dbg_rd_val,
	output logic dbg_compl,
	output dmem_pkg::bus_req_t bus_req,
	output logic access
);

	import dmem_pkg::*;

	word_t wr_data;
	word_t mem_rd_val;
	word_t wr_val_bypass;
	reg_sel_t rd_sel_bypass;
	reg_sel_t mem_rd;
	logic update_rd_bypass;
	logic mem_update_rd;
	acc_width_t mem_width;
	logic [1:0] byte_addr;

	////////////////////////////////////////////////////////////////////////////
	// bus request, debug port wins when enabled
	////////////////////////////////////////////////////////////////////////////

	assign wr_data = dbg_en ? dbg_wr_val : mdr;
	assign mem_width = dbg_en ? dbg_width : width;
	assign byte_addr = dbg_en ? dbg_addr[1:0] : addr[1:0];
	assign access = dbg_en ? dbg_access : (load | store);

	always_comb begin
		bus_req.addr = dbg_en ? dbg_addr[31:2] : addr[31:2];
		bus_req.wr_en = dbg_en ? dbg_wr_en : mem_wr_en;
		case (mem_width)
			ACC_BYTE: begin
				bus_req.byte_en = 4'b0001 << byte_addr;
				bus_req.wr_data = wr_data << {byte_addr, 3'b000};
				mem_rd_val = (d_data >> {byte_addr, 3'b000}) & 32'h0000_00ff;
			end
			ACC_HALF: begin
				bus_req.byte_en = 4'b0011 << {byte_addr[1], 1'b0};
				bus_req.wr_data = wr_data << {byte_addr[1], 4'b0000};
				mem_rd_val = (d_data >> {byte_addr[1], 4'b0000}) & 32'h0000_ffff;
			end
			default: begin
				bus_req.byte_en = 4'b1111;
				bus_req.wr_data = wr_data;
				mem_rd_val = d_data;
			end
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// write-back bypass and load destination
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		wr_val_bypass <= wr_val;
		rd_sel_bypass <= rd_sel;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			update_rd_bypass <= 1'b0;
			mem_update_rd <= 1'b0;
			mem_rd <= '0;
		end else begin
			update_rd_bypass <= update_rd;
			if (load)
				mem_rd <= rd_sel; // destination captured at issue.
			if (load || store)
				mem_update_rd <= load;
			else if (complete)
				mem_update_rd <= 1'b0;
		end
	end

	assign complete = d_ack | d_error;
	assign data_abort = d_error;

	assign reg_wr_val = complete ? mem_rd_val : wr_val_bypass;
	assign rd_sel_out = complete ? mem_rd : rd_sel_bypass;
	// aborted and debug accesses leave the register file alone.
	assign update_rd_out = complete ? (mem_update_rd & ~d_error & ~dbg_en) :
		update_rd_bypass;
	assign busy = load | store | update_rd_out;

	assign dbg_rd_val = mem_rd_val;
	assign dbg_compl = dbg_en & complete;

endmodule

`default_nettype wire

/* logic/bus_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dmem_settings.svh"

module bus_decoder (
	input logic clk,
	input logic rst,
	input logic access,
	input dmem_pkg::bus_req_t bus_req,
	input logic resp_done,
	output dmem_pkg::bank_req_t bank_req [`DMEM_NUM_BANKS],
	output logic unmapped,
	output dmem_pkg::bank_sel_t bank_sel
);

	import dmem_pkg::*;

	dec_state_t state;
	logic mapped;
	logic start;

	assign bank_sel = bus_req.addr[`DMEM_MAP_BITS-1:`DMEM_IDX_BITS];
	assign mapped = ~|bus_req.addr[$bits(bus_addr_t)-1:`DMEM_MAP_BITS];
	assign start = access && state == DEC_IDLE; // first cycle of a held access.

	always_comb begin
		for (int i = 0; i < `DMEM_NUM_BANKS; i++) begin
			bank_req[i].strobe = start && mapped && bank_sel == bank_sel_t'(i);
			bank_req[i].wr_en = bus_req.wr_en;
			bank_req[i].idx = bus_req.addr[`DMEM_IDX_BITS-1:0];
			bank_req[i].byte_en = bus_req.byte_en;
			bank_req[i].wr_data = bus_req.wr_data;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// access tracking
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= DEC_IDLE;
			unmapped <= 1'b0;
		end else begin
			unmapped <= start && !mapped; // no bank sees this one.
			case (state)
				DEC_IDLE:
					if (access)
						state <= DEC_WAIT;
				DEC_WAIT:
					if (resp_done)
						state <= DEC_IDLE; // held access ignored until here.
				default:
					state <= DEC_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

/* logic/ram_bank.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dmem_settings.svh"

module ram_bank (
	input logic clk,
	input logic rst,
	input dmem_pkg::bank_req_t bank_req,
	output dmem_pkg::bank_resp_t bank_resp
);

	import dmem_pkg::*;

	word_t mem [`DMEM_BANK_WORDS];
	word_t rd_data;
	logic ack;

	////////////////////////////////////////////////////////////////////////////
	// storage, old word returned on a write
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (bank_req.strobe) begin
			rd_data <= mem[bank_req.idx];
			for (int i = 0; i < 4; i++) begin
				if (bank_req.wr_en && bank_req.byte_en[i])
					mem[bank_req.idx][i*8 +: 8] <= bank_req.wr_data[i*8 +: 8];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst)
			ack <= 1'b0;
		else
			ack <= bank_req.strobe; // one cycle after the strobe.
	end

	assign bank_resp.ack = ack;
	assign bank_resp.data = rd_data;

endmodule

`default_nettype wire

/* logic/bus_return.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dmem_settings.svh"

module bus_return (
	input logic clk,
	input logic rst,
	input dmem_pkg::bank_resp_t bank_resp [`DMEM_NUM_BANKS],
	input logic unmapped,
	input dmem_pkg::bank_sel_t bank_sel,
	output logic d_ack,
	output logic d_error,
	output dmem_pkg::word_t d_data,
	output logic resp_done
);

	import dmem_pkg::*;

	bank_sel_t sel_q;

	// bank answers one cycle after the strobe, so last cycle's select applies.
	always_ff @(posedge clk) begin
		sel_q <= bank_sel;
		d_data <= unmapped ? '0 : bank_resp[sel_q].data;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			d_ack <= 1'b0;
			d_error <= 1'b0;
		end else begin
			d_ack <= bank_resp[sel_q].ack;
			d_error <= unmapped; // abort lands with the same latency as a hit.
		end
	end

	assign resp_done = d_ack | d_error;

endmodule

`default_nettype wire

/* logic/dmem_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dmem_settings.svh"

module dmem_top (
	input logic clk,
	input logic rst,
	input logic load,
	input logic store,
	input dmem_pkg::word_t addr,
	input dmem_pkg::word_t mdr,
	input logic mem_wr_en,
	input dmem_pkg::acc_width_t width,
	input dmem_pkg::word_t wr_val,
	input logic update_rd,
	input dmem_pkg::reg_sel_t rd_sel,
	input logic dbg_en,
	input logic dbg_access,
	input logic dbg_wr_en,
	input dmem_pkg::word_t dbg_addr,
	input dmem_pkg::acc_width_t dbg_width,
	input dmem_pkg::word_t dbg_wr_val,
	output dmem_pkg::word_t reg_wr_val,
	output logic update_rd_out,
	output dmem_pkg::reg_sel_t rd_sel_out,
	output logic complete,
	output logic data_abort,
	output logic busy,
	output dmem_pkg::word_t dbg_rd_val,
	output logic dbg_compl
);

	import dmem_pkg::*;

	bus_req_t bus_req;
	logic access;
	bank_req_t bank_req [`DMEM_NUM_BANKS];
	bank_resp_t bank_resp [`DMEM_NUM_BANKS];
	logic unmapped;
	bank_sel_t bank_sel;
	logic resp_done;
	logic d_ack;
	logic d_error;
	word_t d_data;

	mem_stage mem_stage_inst (
		.clk(clk), .rst(rst), .load(load), .store(store), .addr(addr), .mdr(mdr),
		.mem_wr_en(mem_wr_en), .width(width), .wr_val(wr_val), .update_rd(update_rd),
		.rd_sel(rd_sel), .dbg_en(dbg_en), .dbg_access(dbg_access),
		.dbg_wr_en(dbg_wr_en), .dbg_addr(dbg_addr), .dbg_width(dbg_width),
		.dbg_wr_val(dbg_wr_val), .d_ack(d_ack), .d_error(d_error), .d_data(d_data),
		.reg_wr_val(reg_wr_val), .update_rd_out(update_rd_out), .rd_sel_out(rd_sel_out),
		.complete(complete), .data_abort(data_abort), .busy(busy),
		.dbg_rd_val(dbg_rd_val), .dbg_compl(dbg_compl), .bus_req(bus_req),
		.access(access)
	);

	bus_decoder bus_decoder_inst (
		.clk(clk), .rst(rst), .access(access), .bus_req(bus_req),
		.resp_done(resp_done), .bank_req(bank_req), .unmapped(unmapped),
		.bank_sel(bank_sel)
	);

	for (genvar i = 0; i < `DMEM_NUM_BANKS; i++) begin : g_bank
		ram_bank ram_bank_inst (
			.clk(clk), .rst(rst), .bank_req(bank_req[i]), .bank_resp(bank_resp[i])
		);
	end

	bus_return bus_return_inst (
		.clk(clk), .rst(rst), .bank_resp(bank_resp), .unmapped(unmapped),
		.bank_sel(bank_sel), .d_ack(d_ack), .d_error(d_error), .d_data(d_data),
		.resp_done(resp_done)
	);

endmodule

`default_nettype wire

/* tb/dmem_sva.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dmem_settings.svh"

module dmem_sva (
	input logic clk,
	input logic rst,
	input logic access,
	input logic complete,
	input logic data_abort,
	input logic update_rd_out,
	input dmem_pkg::bank_req_t bank_req [`DMEM_NUM_BANKS]
);

	import dmem_pkg::*;

	logic [`DMEM_NUM_BANKS-1:0] strobes;
	logic in_flight;
	logic start;
	logic latency_fail = 1'b0;
	logic repeat_fail = 1'b0;
	logic multi_fail = 1'b0;
	logic abort_fail = 1'b0;
	logic any_fail;

	always_comb begin
		for (int i = 0; i < `DMEM_NUM_BANKS; i++)
			strobes[i] = bank_req[i].strobe;
	end

	// an access is in flight from the cycle after it starts until complete.
	always_ff @(posedge clk) begin
		if (rst)
			in_flight <= 1'b0;
		else if (complete)
			in_flight <= 1'b0;
		else if (access)
			in_flight <= 1'b1;
	end

	assign start = access && !in_flight;
	assign any_fail = latency_fail | repeat_fail | multi_fail | abort_fail;

	////////////////////////////////////////////////////////////////////////////
	// bus protocol
	////////////////////////////////////////////////////////////////////////////

	complete_latency: assert property (@(posedge clk) disable iff (rst)
		complete == $past(start, 2))
		else begin
			latency_fail = 1'b1;
			$error("complete did not come exactly 2 cycles after the access start");
		end

	strobe_once: assert property (@(posedge clk) disable iff (rst)
		strobes != '0 |-> start)
		else begin
			repeat_fail = 1'b1;
			$error("bank strobed outside the first cycle of an access");
		end

	strobe_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(strobes))
		else begin
			multi_fail = 1'b1;
			$error("more than one bank strobed in a cycle");
		end

	abort_no_write: assert property (@(posedge clk) disable iff (rst)
		!(update_rd_out && data_abort))
		else begin
			abort_fail = 1'b1;
			$error("register update together with a data abort");
		end

endmodule

bind dmem_top dmem_sva dmem_sva_inst (
	.clk(clk), .rst(rst), .access(access), .complete(complete),
	.data_abort(data_abort), .update_rd_out(update_rd_out), .bank_req(bank_req)
);

`default_nettype wire

/* tb/dmem_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module dmem_tb;

	import dmem_pkg::*;

	localparam int WORD_RUNS = 8;
	localparam int UNMAPPED_RUNS = 4;
	localparam int BYPASS_RUNS = 16;
	localparam int CHAIN_RUNS = 6;
	localparam int ACCESS_LIMIT = 10; // cycles to wait for complete.
	localparam int ACCESS_CYCLES = 5; // drive, three busy cycles, drop.
	localparam int TOTAL_ACCESSES = 2 * WORD_RUNS + 24 + 4 * UNMAPPED_RUNS + 6 + 2 * CHAIN_RUNS;
	localparam int WATCHDOG_CYCLES = TOTAL_ACCESSES * ACCESS_CYCLES + 2 * BYPASS_RUNS + 100;
	localparam acc_width_t WORD_W = 2'd2;

	logic clk = 1'b0;
	logic rst;
	logic load, store, mem_wr_en, update_rd;
	logic dbg_en, dbg_access, dbg_wr_en;
	word_t addr, mdr, wr_val, dbg_addr, dbg_wr_val;
	acc_width_t width, dbg_width;
	reg_sel_t rd_sel;
	word_t reg_wr_val, dbg_rd_val;
	logic update_rd_out, complete, data_abort, busy, dbg_compl;
	reg_sel_t rd_sel_out;

	logic [31:0] lfsr_state = 32'h5d1a;
	logic [7:0] model [4096]; // byte image of the mapped 4 KB.
	int checks = 0;
	int errors = 0;
	int checks_mark = 0;
	int errors_mark = 0;
	int tests_done = 0;
	int access_count = 0;
	int complete_count = 0;

	// captured in the cycle that complete is high.
	word_t res_val, res_dbg_val;
	logic res_abort, res_upd, res_dbg_compl, res_busy;
	reg_sel_t res_rd;

	dmem_top dmem_top_inst (
		.clk(clk), .rst(rst), .load(load), .store(store), .addr(addr), .mdr(mdr),
		.mem_wr_en(mem_wr_en), .width(width), .wr_val(wr_val), .update_rd(update_rd),
		.rd_sel(rd_sel), .dbg_en(dbg_en), .dbg_access(dbg_access), .dbg_wr_en(dbg_wr_en),
		.dbg_addr(dbg_addr), .dbg_width(dbg_width), .dbg_wr_val(dbg_wr_val),
		.reg_wr_val(reg_wr_val), .update_rd_out(update_rd_out), .rd_sel_out(rd_sel_out),
		.complete(complete), .data_abort(data_abort), .busy(busy),
		.dbg_rd_val(dbg_rd_val), .dbg_compl(dbg_compl)
	);

	always #2 clk = ~clk;

	always @(negedge clk) begin
		if (!rst && complete)
			complete_count++;
	end

	////////////////////////////////////////////////////////////////////////////
	// random numbers and the memory model
	////////////////////////////////////////////////////////////////////////////

	function automatic word_t next_random(input int nbits);
		word_t r;
		r = '0;
		for (int i = 0; i < nbits; i++) begin
			r = {r[30:0], lfsr_state[0]};
			lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h8020_0003 : lfsr_state >> 1;
		end
		return r;
	endfunction

	function automatic word_t random_addr(input int bank);
		word_t r;
		r = next_random(8);
		return {20'h0, 2'(bank), r[7:0], 2'b00};
	endfunction

	task automatic model_store(input word_t a, input word_t d, input acc_width_t w);
		logic [11:0] b;
		b = a[11:0];
		case (w)
			ACC_BYTE: model[b] = d[7:0];
			ACC_HALF: begin
				model[{b[11:1], 1'b0}] = d[7:0];
				model[{b[11:1], 1'b1}] = d[15:8];
			end
			default: begin
				for (int i = 0; i < 4; i++)
					model[{b[11:2], 2'(i)}] = d[i*8 +: 8];
			end
		endcase
	endtask

	function automatic word_t expected_load(input word_t a, input acc_width_t w);
		logic [11:0] b;
		b = a[11:0];
		case (w)
			ACC_BYTE: return {24'h0, model[b]};
			ACC_HALF: return {16'h0, model[{b[11:1], 1'b1}], model[{b[11:1], 1'b0}]};
			default: return {model[{b[11:2], 2'd3}], model[{b[11:2], 2'd2}],
				model[{b[11:2], 2'd1}], model[{b[11:2], 2'd0}]};
		endcase
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// checks and accesses
	////////////////////////////////////////////////////////////////////////////

	task automatic check_value(input string what, input word_t got, input word_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic report_test(input string name);
		$display("test %-12s checks %0d, errors %0d", name, checks - checks_mark,
			errors - errors_mark);
		checks_mark = checks;
		errors_mark = errors;
		tests_done++;
	endtask

	task automatic run_access(input logic dbg, input logic wr, input word_t a, input word_t d,
			input acc_width_t w, input reg_sel_t rd);
		int waited;
		waited = 0;
		@(posedge clk);
		if (dbg) begin
			dbg_en <= 1'b1;
			dbg_access <= 1'b1;
			dbg_wr_en <= wr;
			dbg_addr <= a;
			dbg_width <= w;
			dbg_wr_val <= d;
		end else begin
			load <= !wr;
			store <= wr;
			mem_wr_en <= wr;
			addr <= a;
			mdr <= d;
			width <= w;
			rd_sel <= rd;
		end
		access_count++;
		do begin
			@(negedge clk);
			waited++;
		end while (!complete && waited < ACCESS_LIMIT);
		if (!complete) begin
			errors++;
			$display("access to address %h got no complete within %0d cycles", a, ACCESS_LIMIT);
		end
		res_val = reg_wr_val;
		res_abort = data_abort;
		res_upd = update_rd_out;
		res_rd = rd_sel_out;
		res_dbg_compl = dbg_compl;
		res_dbg_val = dbg_rd_val;
		res_busy = busy;
		@(posedge clk);
		load <= 1'b0; // dropped the cycle after complete.
		store <= 1'b0;
		dbg_en <= 1'b0;
		dbg_access <= 1'b0;
		if (wr && a[31:12] == '0)
			model_store(a, d, w);
	endtask

	task automatic load_check(input word_t a, input acc_width_t w);
		reg_sel_t rd;
		word_t exp;
		rd = reg_sel_t'(next_random(4));
		exp = expected_load(a, w);
		run_access(1'b0, 1'b0, a, '0, w, rd);
		check_value("load data", res_val, exp);
		check_value("update_rd_out", word_t'(res_upd), 32'd1);
		check_value("rd_sel_out", word_t'(res_rd), word_t'(rd));
		check_value("data_abort", word_t'(res_abort), 32'd0);
		check_value("dbg_compl on load", word_t'(res_dbg_compl), 32'd0);
	endtask

	task automatic debug_check(input word_t a, input acc_width_t w);
		word_t exp;
		exp = expected_load(a, w);
		run_access(1'b1, 1'b0, a, '0, w, '0);
		check_value("dbg_rd_val", res_dbg_val, exp);
		check_value("dbg_compl", word_t'(res_dbg_compl), 32'd1);
		check_value("update_rd_out on debug", word_t'(res_upd), 32'd0);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// test sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("watchdog expired after %0d cycles, run stopped", WATCHDOG_CYCLES);
		$display("Finished with errors");
		$finish;
	end

	initial begin
		word_t a;
		word_t bad;
		word_t v;
		word_t u;
		word_t r;
		word_t chain [CHAIN_RUNS];
		int count_mark;
		int access_mark;
		rst = 1'b1;
		{load, store, mem_wr_en, update_rd} = '0;
		{dbg_en, dbg_access, dbg_wr_en} = '0;
		{addr, mdr, wr_val, dbg_addr, dbg_wr_val} = '0;
		width = WORD_W;
		dbg_width = WORD_W;
		rd_sel = '0;
		repeat (4) @(posedge clk);
		rst <= 1'b0;

		for (int i = 0; i < WORD_RUNS; i++) begin
			a = random_addr(i % 4);
			run_access(1'b0, 1'b1, a, next_random(32), WORD_W, '0);
			check_value("busy on store", word_t'(res_busy), 32'd1);
			load_check(a, i[0] ? 2'd3 : WORD_W); // width 3 reads a full word too.
		end
		report_test("word_access");

		for (int off = 0; off < 4; off++) begin
			a = random_addr(off);
			run_access(1'b0, 1'b1, a, next_random(32), WORD_W, '0);
			run_access(1'b0, 1'b1, a + word_t'(off), next_random(32), ACC_BYTE, '0);
			load_check(a, WORD_W);
			load_check(a + word_t'(off), ACC_BYTE);
		end
		for (int off = 0; off < 4; off += 2) begin
			a = random_addr(off + 1);
			run_access(1'b0, 1'b1, a, next_random(32), WORD_W, '0);
			run_access(1'b0, 1'b1, a + word_t'(off), next_random(32), ACC_HALF, '0);
			load_check(a, WORD_W);
			load_check(a + word_t'(off), ACC_HALF);
		end
		report_test("lane_merge");

		for (int i = 0; i < UNMAPPED_RUNS; i++) begin
			a = random_addr(i);
			run_access(1'b0, 1'b1, a, next_random(32), WORD_W, '0);
			bad = a | (next_random(20) << 12) | 32'h0000_1000; // aliases a in the low 4 KB.
			run_access(1'b0, 1'b1, bad, next_random(32), WORD_W, '0);
			check_value("abort on store", word_t'(res_abort), 32'd1);
			run_access(1'b0, 1'b0, bad, '0, WORD_W, 4'd5);
			check_value("abort on load", word_t'(res_abort), 32'd1);
			check_value("update_rd_out on abort", word_t'(res_upd), 32'd0);
			load_check(a, WORD_W);
		end
		report_test("unmapped");

		for (int i = 0; i < BYPASS_RUNS; i++) begin
			v = next_random(32);
			u = next_random(1);
			r = next_random(4);
			@(posedge clk);
			wr_val <= v;
			update_rd <= u[0];
			rd_sel <= reg_sel_t'(r);
			@(posedge clk);
			@(negedge clk);
			check_value("reg_wr_val bypass", reg_wr_val, v);
			check_value("update_rd_out bypass", word_t'(update_rd_out), word_t'(u[0]));
			check_value("rd_sel_out bypass", word_t'(rd_sel_out), word_t'(reg_sel_t'(r)));
			check_value("busy", word_t'(busy), word_t'(u[0]));
		end
		@(posedge clk);
		update_rd <= 1'b0;
		report_test("bypass");

		a = random_addr(2);
		run_access(1'b1, 1'b1, a, next_random(32), WORD_W, '0);
		check_value("dbg_compl on write", word_t'(res_dbg_compl), 32'd1);
		check_value("update_rd_out on debug", word_t'(res_upd), 32'd0);
		run_access(1'b1, 1'b1, a + 32'd3, next_random(32), ACC_BYTE, '0);
		debug_check(a, WORD_W);
		debug_check(a + 32'd2, ACC_HALF);
		load_check(a, WORD_W);
		report_test("debug_port");

		for (int i = 0; i < CHAIN_RUNS; i++) begin
			chain[i] = random_addr(i % 4);
			run_access(1'b0, 1'b1, chain[i], next_random(32), WORD_W, '0);
		end
		count_mark = complete_count;
		access_mark = access_count;
		for (int i = 0; i < CHAIN_RUNS; i++)
			load_check(chain[i], WORD_W);
		check_value("complete pulses", word_t'(complete_count - count_mark),
			word_t'(access_count - access_mark));
		report_test("back_to_back");

		repeat (2) @(posedge clk);
		$display("tests %0d, checks %0d, errors %0d, assertion failure seen %0b", tests_done,
			checks, errors, dmem_top_inst.dmem_sva_inst.any_fail);
		if (errors == 0 && !dmem_top_inst.dmem_sva_inst.any_fail) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* flist.f */
+incdir+include
logic/dmem_pkg.sv
logic/mem_stage.sv
logic/bus_decoder.sv
logic/ram_bank.sv
logic/bus_return.sv
logic/dmem_top.sv
tb/dmem_sva.sv
tb/dmem_tb.sv

/* Makefile */
# Verilator build and run for the data memory subsystem testbench.

VERILATOR ?= verilator
TOP ?= dmem_tb
FLIST ?= flist.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --assert --timescale 1ns/1ps
SIM_ARGS ?= +verilator+error+limit+1000

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard logic/*.sv tb/*.sv include/*.svh)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: compile
	$(SIM_BIN) $(SIM_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Finished with errors" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "Finished with no errors" $(LOG); then \
		echo "simulation stopped without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
